//--- hw/ts_submit_pkg.sv
/*
 * Shared sizes and types of the time-sensitive submit manager.
 * Modules take their default parameters from here and import the enums.
 */

package ts_submit_pkg;

    // default sizes, the top level overrides them through its parameters
    localparam int DESC_W_DEF   = 13;  // descriptor (bufid) width
    localparam int FLOW_NUM_DEF = 32;  // number of ts flows cached
    localparam int PKT_TYPE_W   = 3;   // packet type field from the input queue

    // packet type codes as carried by the input queue
    typedef enum logic [PKT_TYPE_W-1:0] {
        PKT_TS_CDT = 3'd0,  // ts control data traffic
        PKT_TS_RC  = 3'd1,  // ts rate constrained
        PKT_TS_TT  = 3'd2,  // ts time triggered
        PKT_RC_BE  = 3'd3,  // rc handled as best effort
        PKT_BE     = 3'd4,  // plain best effort
        PKT_PTP    = 3'd5,
        PKT_NMAC   = 3'd6,
        PKT_RSVD   = 3'd7
    } pkt_type_e;

    // submit state machine
    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,  // wait for a submit request
        S_RD_1     = 3'd1,  // first ram read stage
        S_RD_2     = 3'd2,  // second ram read stage
        S_GET      = 3'd3,  // latch ram data to the output
        S_WAIT_ACK = 3'd4   // hold descriptor until lookup takes it
    } submit_state_e;

    // only the three ts codes mark a flow as pending
    function automatic logic is_ts_type(input pkt_type_e t);
        return (t == PKT_TS_CDT) || (t == PKT_TS_RC) || (t == PKT_TS_TT);
    endfunction

endpackage

//--- hw/ts_descriptor_ram.sv
/*
 * Simple dual-port descriptor cache, one entry per flow.
 * Read data appears two cycles after i_rd, like the vendor RAM it stands in for.
 */

`timescale 1ns/1ns

module ts_descriptor_ram #(
    parameter int DESC_W   = ts_submit_pkg::DESC_W_DEF,
    parameter int FLOW_NUM = ts_submit_pkg::FLOW_NUM_DEF
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_wr,      // write strobe
    input  logic [$clog2(FLOW_NUM)-1:0] i_waddr,
    input  logic [DESC_W-1:0]           i_wdata,
    input  logic                        i_rd,      // read strobe
    input  logic [$clog2(FLOW_NUM)-1:0] i_raddr,
    output logic [DESC_W-1:0]           o_rdata    // valid 2 cycles after i_rd
);

    logic [DESC_W-1:0] mem [FLOW_NUM];  // flow indexed storage
    logic [DESC_W-1:0] rd_q1;           // first read register
    logic              rd_d1;           // i_rd delayed, enables stage two

    // write port, no reset on the array
    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // two-stage read, same-address write returns the old word
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_q1   <= '0;
            rd_d1   <= 1'b0;
            o_rdata <= '0;
        end else begin
            rd_d1 <= i_rd;
            if (i_rd) begin
                rd_q1 <= mem[i_raddr];  // stage one
            end
            if (rd_d1) begin
                o_rdata <= rd_q1;       // stage two
            end
        end
    end

endmodule

//--- hw/ts_flow_flags.sv
/*
 * Pending flag per ts flow. Set by an input queue announce of a ts packet,
 * cleared when the submit side sees the descriptor taken. Clear wins.
 */

`timescale 1ns/1ns

module ts_flow_flags #(
    parameter int FLOW_NUM = ts_submit_pkg::FLOW_NUM_DEF
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_hiq_wr,        // announce strobe
    input  ts_submit_pkg::pkt_type_e    i_hiq_pkt_type,
    input  logic [$clog2(FLOW_NUM)-1:0] i_hiq_flow,
    input  logic                        i_clr,           // clear strobe from fsm
    input  logic [$clog2(FLOW_NUM)-1:0] i_clr_flow,
    output logic [FLOW_NUM-1:0]         o_pending
);

    import ts_submit_pkg::*;

    localparam int FLOW_W = $clog2(FLOW_NUM);

    logic set_hit;  // announce of a ts type this cycle

    assign set_hit = i_hiq_wr && is_ts_type(i_hiq_pkt_type);

    //*********************************************************************
    // one bit per flow
    //*********************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pending <= '0;
        end else begin
            for (int i = 0; i < FLOW_NUM; i++) begin
                if (i_clr && (i_clr_flow == FLOW_W'(i))) begin
                    o_pending[i] <= 1'b0;  // served, takes priority
                end else if (set_hit && (i_hiq_flow == FLOW_W'(i))) begin
                    o_pending[i] <= 1'b1;  // new ts packet queued
                end
            end
        end
    end

endmodule

//--- hw/ts_submit_fsm.sv
/*
 * Submit state machine. Acks every sampled request, reads the descriptor
 * of a pending flow from the cache and holds it until the lookup acks it.
 * A request for a flow without a pending flag gives an underflow pulse.
 */

`timescale 1ns/1ns

module ts_submit_fsm #(
    parameter int DESC_W   = ts_submit_pkg::DESC_W_DEF,
    parameter int FLOW_NUM = ts_submit_pkg::FLOW_NUM_DEF
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    // submit request, held by requester until ack
    input  logic                        i_submit_wr,
    input  logic [$clog2(FLOW_NUM)-1:0] i_submit_flow,
    output logic                        o_submit_ack,
    output logic                        o_underflow,    // one cycle, with the ack
    // flag vector and clear
    input  logic [FLOW_NUM-1:0]         i_pending,
    output logic                        o_clr,
    output logic [$clog2(FLOW_NUM)-1:0] o_clr_flow,
    // ram read side
    output logic                        o_rd,
    output logic [$clog2(FLOW_NUM)-1:0] o_rd_addr,
    input  logic [DESC_W-1:0]           i_rd_data,
    // descriptor to lookup
    output logic [DESC_W-1:0]           o_desc,
    output logic                        o_desc_valid,
    input  logic                        i_desc_ack
);

    import ts_submit_pkg::*;

    submit_state_e state;
    logic          req_take;  // request accepted this cycle
    logic          req_hit;   // requested flow has its flag set

    // no resample while the ack of the last request is still out
    assign req_take = (state == S_IDLE) && i_submit_wr && !o_submit_ack;
    assign req_hit  = i_pending[i_submit_flow];

    // clear the flag on the same edge that drops o_desc_valid
    assign o_clr      = (state == S_WAIT_ACK) && i_desc_ack;
    assign o_clr_flow = o_rd_addr;  // address held for the whole service

    //*********************************************************************
    // state machine and registered outputs
    //*********************************************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            o_submit_ack <= 1'b0;
            o_underflow  <= 1'b0;
            o_rd         <= 1'b0;
            o_rd_addr    <= '0;
            o_desc       <= '0;
            o_desc_valid <= 1'b0;
        end else begin
            // strobes default low
            o_submit_ack <= 1'b0;
            o_underflow  <= 1'b0;
            o_rd         <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req_take) begin
                        o_submit_ack <= 1'b1;  // always acked
                        if (req_hit) begin
                            o_rd      <= 1'b1;  // start ram read
                            o_rd_addr <= i_submit_flow;
                            state     <= S_RD_1;
                        end else begin
                            o_underflow <= 1'b1;  // nothing cached, stay idle
                        end
                    end
                end
                S_RD_1: begin
                    state <= S_RD_2;  // ram stage one
                end
                S_RD_2: begin
                    state <= S_GET;   // ram stage two
                end
                S_GET: begin
                    o_desc       <= i_rd_data;  // data valid now
                    o_desc_valid <= 1'b1;
                    state        <= S_WAIT_ACK;
                end
                S_WAIT_ACK: begin
                    // stall here as long as lookup is busy
                    if (i_desc_ack) begin
                        o_desc       <= '0;
                        o_desc_valid <= 1'b0;
                        state        <= S_IDLE;
                    end
                end
                default: begin
                    o_desc       <= '0;
                    o_desc_valid <= 1'b0;
                    state        <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/ts_submit_mgmt.sv
/*
 * Top level of the ts submit manager. Connects the descriptor cache,
 * the per-flow pending flags and the submit state machine.
 */

`timescale 1ns/1ns

module ts_submit_mgmt #(
    parameter int DESC_W   = ts_submit_pkg::DESC_W_DEF,
    parameter int FLOW_NUM = ts_submit_pkg::FLOW_NUM_DEF
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    // input queue announce
    input  logic                        i_hiq_wr,
    input  ts_submit_pkg::pkt_type_e    i_hiq_pkt_type,
    input  logic [$clog2(FLOW_NUM)-1:0] i_hiq_flow,
    // descriptor write into the cache
    input  logic                        i_desc_wr,
    input  logic [$clog2(FLOW_NUM)-1:0] i_desc_waddr,
    input  logic [DESC_W-1:0]           i_desc_wdata,
    // submit request
    input  logic                        i_submit_wr,
    input  logic [$clog2(FLOW_NUM)-1:0] i_submit_flow,
    output logic                        o_submit_ack,
    // descriptor to lookup
    output logic [DESC_W-1:0]           o_desc,
    output logic                        o_desc_valid,
    input  logic                        i_desc_ack,
    // status
    output logic                        o_underflow,
    output logic [FLOW_NUM-1:0]         o_flow_pending
);

    localparam int FLOW_W = $clog2(FLOW_NUM);

    logic              rd_en;          // fsm -> ram
    logic [FLOW_W-1:0] rd_addr;
    logic [DESC_W-1:0] rd_data;        // ram -> fsm
    logic              flag_clr;       // fsm -> flags
    logic [FLOW_W-1:0] flag_clr_flow;

    ts_descriptor_ram #(
        .DESC_W   (DESC_W),
        .FLOW_NUM (FLOW_NUM)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_desc_wr),
        .i_waddr (i_desc_waddr),
        .i_wdata (i_desc_wdata),
        .i_rd    (rd_en),
        .i_raddr (rd_addr),
        .o_rdata (rd_data)
    );

    ts_flow_flags #(
        .FLOW_NUM (FLOW_NUM)
    ) u_flags (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_hiq_wr       (i_hiq_wr),
        .i_hiq_pkt_type (i_hiq_pkt_type),
        .i_hiq_flow     (i_hiq_flow),
        .i_clr          (flag_clr),
        .i_clr_flow     (flag_clr_flow),
        .o_pending      (o_flow_pending)
    );

    ts_submit_fsm #(
        .DESC_W   (DESC_W),
        .FLOW_NUM (FLOW_NUM)
    ) u_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_submit_wr   (i_submit_wr),
        .i_submit_flow (i_submit_flow),
        .o_submit_ack  (o_submit_ack),
        .o_underflow   (o_underflow),
        .i_pending     (o_flow_pending),
        .o_clr         (flag_clr),
        .o_clr_flow    (flag_clr_flow),
        .o_rd          (rd_en),
        .o_rd_addr     (rd_addr),
        .i_rd_data     (rd_data),
        .o_desc        (o_desc),
        .o_desc_valid  (o_desc_valid),
        .i_desc_ack    (i_desc_ack)
    );

endmodule

//--- testbench/ts_submit_chk.sv
/*
 * Protocol assertions for the ts submit manager top level.
 * Bound into every ts_submit_mgmt instance.
 */

`timescale 1ns/1ns

module ts_submit_chk #(
    parameter int DESC_W = ts_submit_pkg::DESC_W_DEF
) (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_submit_ack,
    input logic              i_underflow,
    input logic [DESC_W-1:0] i_desc,
    input logic              i_desc_valid,
    input logic              i_desc_ack
);

    int assert_fails = 0;  // failed assertions so far

    // ack is a single cycle strobe
    a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_submit_ack |=> !i_submit_ack)
    else begin
        assert_fails++;
        $error("submit ack high for two cycles");
    end

    a_underflow_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_underflow |-> i_submit_ack)  // underflow only with the ack
    else begin
        assert_fails++;
        $error("underflow without submit ack");
    end

    // descriptor held until lookup takes it
    a_desc_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_desc_valid && !i_desc_ack) |=> (i_desc_valid && $stable(i_desc)))
    else begin
        assert_fails++;
        $error("descriptor changed or dropped before ack");
    end

    a_reset_valid: assert property (@(posedge i_clk) !i_rst_n |-> !i_desc_valid)
    else begin
        assert_fails++;
        $error("descriptor valid during reset");
    end

endmodule

bind ts_submit_mgmt ts_submit_chk #(.DESC_W(DESC_W)) u_chk (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_submit_ack (o_submit_ack),
    .i_underflow  (o_underflow),
    .i_desc       (o_desc),
    .i_desc_valid (o_desc_valid),
    .i_desc_ack   (i_desc_ack)
);

//--- testbench/tb_ts_submit_mgmt.sv
/*
 * Testbench for the ts submit manager. Random announces, cache writes and
 * submit requests from a fixed seed, compared with a model of flags and RAM.
 */

`timescale 1ns/1ns

module tb_ts_submit_mgmt;

    import ts_submit_pkg::*;

    localparam int DESC_W   = DESC_W_DEF;
    localparam int FLOW_NUM = FLOW_NUM_DEF;
    localparam int FLOW_W   = $clog2(FLOW_NUM);
    localparam int CLK_NS   = 10;
    localparam int N_TRANS  = 300;  // submit requests in the run
    // 20 cycles per request plus cache fill and some slack
    localparam int TIMEOUT  = (N_TRANS * 20 + FLOW_NUM + 50) * CLK_NS;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_hiq_wr;
    pkt_type_e         i_hiq_pkt_type;
    logic [FLOW_W-1:0] i_hiq_flow;
    logic              i_desc_wr;
    logic [FLOW_W-1:0] i_desc_waddr;
    logic [DESC_W-1:0] i_desc_wdata;
    logic              i_submit_wr;
    logic [FLOW_W-1:0] i_submit_flow;
    logic              o_submit_ack;
    logic [DESC_W-1:0] o_desc;
    logic              o_desc_valid;
    logic              i_desc_ack;
    logic              o_underflow;
    logic [FLOW_NUM-1:0] o_flow_pending;

    integer              seed;
    int                  err_desc;
    int                  err_flags;
    int                  err_bit;
    logic [DESC_W-1:0]   m_ram [FLOW_NUM];  // model of the cache
    logic [FLOW_NUM-1:0] m_flags;           // model of the pending flags

    ts_submit_mgmt #(
        .DESC_W   (DESC_W),
        .FLOW_NUM (FLOW_NUM)
    ) u_ts_submit_mgmt (.*);

    always #(CLK_NS / 2) i_clk = ~i_clk;

    //*********************************************************************
    // compare tasks
    //*********************************************************************
    task automatic check_desc(input logic [DESC_W-1:0] got, input logic [DESC_W-1:0] exp);
        if (got !== exp) begin
            err_desc++;
            $display("Error o_desc: got 0x%h, expected 0x%h at %0t ns", got, exp, $time);
        end
    endtask

    task automatic check_flags(input logic [FLOW_NUM-1:0] got, input logic [FLOW_NUM-1:0] exp);
        if (got !== exp) begin
            err_flags++;
            $display("Error o_flow_pending: got 0x%h, expected 0x%h at %0t ns",
                     got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_bit++;
            $display("Error %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    // one clock through the posedge with the flags compared
    task automatic tick();
        @(negedge i_clk);
        check_flags(o_flow_pending, m_flags);
    endtask

    // random announce and cache write for the coming edge and the model update
    task automatic noise(input logic same_flow, input logic [FLOW_W-1:0] flow);
        logic [PKT_TYPE_W-1:0] rnd_type;
        rnd_type       = $random(seed);
        i_hiq_wr       = (($random(seed) & 7) == 0);  // about 1 in 8
        i_hiq_pkt_type = pkt_type_e'(rnd_type);
        i_hiq_flow     = $random(seed);
        if (same_flow) begin
            i_hiq_wr       = 1'b1;  // hit the flow being served
            i_hiq_pkt_type = PKT_TS_TT;
            i_hiq_flow     = flow;
        end
        i_desc_wr    = (($random(seed) & 3) == 0);
        i_desc_waddr = $random(seed);
        i_desc_wdata = $random(seed);
        // only ts_cdt, ts_rc and ts_tt mark a flow
        if (i_hiq_wr && ((i_hiq_pkt_type == PKT_TS_CDT) || (i_hiq_pkt_type == PKT_TS_RC) ||
                         (i_hiq_pkt_type == PKT_TS_TT))) begin
            m_flags[i_hiq_flow] = 1'b1;
        end
        if (i_desc_wr) begin
            m_ram[i_desc_waddr] = i_desc_wdata;
        end
    endtask

    // random flow that half the time moves on to a pending one
    function automatic logic [FLOW_W-1:0] pick_flow();
        logic [FLOW_W-1:0] f;
        f = $random(seed);
        if ((($random(seed) & 1) != 0) && (m_flags != '0)) begin
            while (!m_flags[f]) begin
                f = f + 1'b1;
            end
        end
        return f;
    endfunction

    //*********************************************************************
    // one submit transaction with the request held until the ack
    //*********************************************************************
    task automatic submit(input logic [FLOW_W-1:0] flow);
        logic              hit;
        logic              late;
        logic [DESC_W-1:0] exp_desc;
        int                hold;
        hit           = m_flags[flow];  // flag as seen at sampling edge E
        late          = (($random(seed) & 1) != 0);  // requester sees the ack an edge late
        i_submit_wr   = 1'b1;
        i_submit_flow = flow;
        noise(1'b0, '0);
        tick();                         // edge E
        check_bit("o_submit_ack", o_submit_ack, 1'b1);
        check_bit("o_underflow", o_underflow, !hit);
        i_submit_wr = late;             // a late requester still holds it at E+1
        exp_desc    = m_ram[flow];      // ram reads at E+1 and returns the old word on collision
        for (int k = 1; k <= 3; k++) begin
            noise(1'b0, '0);
            tick();
            i_submit_wr = 1'b0;
            check_bit("o_submit_ack", o_submit_ack, 1'b0);
            check_bit("o_underflow", o_underflow, 1'b0);
            check_bit("o_desc_valid", o_desc_valid, hit && (k == 3));
        end
        if (hit) begin
            check_desc(o_desc, exp_desc);
            hold = $unsigned($random(seed)) % 6;  // lookup busy
            repeat (hold) begin
                noise(1'b0, '0);
                tick();
                check_bit("o_desc_valid", o_desc_valid, 1'b1);
                check_desc(o_desc, exp_desc);
            end
            i_desc_ack = 1'b1;
            noise((($random(seed) & 1) != 0), flow);  // maybe announce same flow
            m_flags[flow] = 1'b0;                    // clear wins
            tick();                                  // edge A
            i_desc_ack = 1'b0;
            check_bit("o_desc_valid", o_desc_valid, 1'b0);
            check_desc(o_desc, '0);
        end
    endtask

    initial begin
        int gap;
        int total;
        seed           = 14;
        err_desc       = 0;
        err_flags      = 0;
        err_bit        = 0;
        m_flags        = '0;
        i_clk          = 1'b0;
        i_rst_n        = 1'b1;
        i_hiq_wr       = 1'b0;
        i_hiq_pkt_type = PKT_BE;
        i_hiq_flow     = '0;
        i_desc_wr      = 1'b0;
        i_desc_waddr   = '0;
        i_desc_wdata   = '0;
        i_submit_wr    = 1'b0;
        i_submit_flow  = '0;
        i_desc_ack     = 1'b0;
        #1 i_rst_n = 1'b0;  // async reset from a clean falling edge
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        // outputs right after reset
        check_bit("o_submit_ack", o_submit_ack, 1'b0);
        check_bit("o_desc_valid", o_desc_valid, 1'b0);
        check_bit("o_underflow", o_underflow, 1'b0);
        check_desc(o_desc, '0);
        check_flags(o_flow_pending, '0);
        // known descriptor for every flow
        for (int f = 0; f < FLOW_NUM; f++) begin
            i_desc_wr    = 1'b1;
            i_desc_waddr = f;
            i_desc_wdata = $random(seed);
            m_ram[f]     = i_desc_wdata;
            tick();
        end
        i_desc_wr = 1'b0;
        for (int t = 0; t < N_TRANS; t++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                noise(1'b0, '0);
                tick();
            end
            submit(pick_flow());
        end
        i_hiq_wr  = 1'b0;
        i_desc_wr = 1'b0;
        tick();
        total = err_desc + err_flags + err_bit + u_ts_submit_mgmt.u_chk.assert_fails;
        $display("error counts: desc %0d, flags %0d, bits %0d, assertions %0d",
                 err_desc, err_flags, err_bit, u_ts_submit_mgmt.u_chk.assert_fails);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout: the submit sequence did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- ts_submit_mgmt.f
hw/ts_submit_pkg.sv
hw/ts_descriptor_ram.sv
hw/ts_flow_flags.sv
hw/ts_submit_fsm.sv
hw/ts_submit_mgmt.sv
testbench/ts_submit_chk.sv
testbench/tb_ts_submit_mgmt.sv

//--- Bender.yml
package:
  name: ts_submit_mgmt

sources:
  - hw/ts_submit_pkg.sv
  - hw/ts_descriptor_ram.sv
  - hw/ts_flow_flags.sv
  - hw/ts_submit_fsm.sv
  - hw/ts_submit_mgmt.sv
  - target: simulation
    files:
      - testbench/ts_submit_chk.sv
      - testbench/tb_ts_submit_mgmt.sv
